// ==== Makefile ====
# Verilator flow for the bp437p16 codec testbench
# every variable below can be set on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= bp437p16_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
PASS_TEXT ?= Verification passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verif/*.svh)

.PHONY: help test clean

help:
	@echo "targets"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables"
	@echo "  VERILATOR FILELIST TOP BUILD_DIR LOG JOBS VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "test: PASS"; \
	else \
		echo "test: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+verif
common/bp_code_pkg.sv
common/bp_host_pkg.sv
bp437/bp437_enc.sv
bp437/bp437_dec.sv
verilog/bp437p16.sv
verif/bp437p16_tb.sv

// ==== bp437/bp437_dec.sv ====
`timescale 1ns/1ps

// one lane of the decoder
// holds the received data for six writes, checks parity on every block and
// repairs a single-symbol burst when it has worked its way to the oldest slot
module bp437_dec
	import bp_code_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ce,     // received word written
	input  logic [bp_sym_w-1:0]  r,      // received symbol {parity, data}
	output logic [bp_data_w-1:0] d       // data of six writes ago, corrected
);

	logic [bp_data_w-1:0] r_dat;     // received data bits
	logic                 r_par;     // received parity bit
	bp_hist_t             dly;       // received data delay line, [0] newest
	logic [bp_depth-2:0]  syn_q;     // stored syndromes of the last six writes
	logic                 syn_now;   // syndrome of the block being written
	bp_sig_t              sig_win;   // seven syndromes, oldest block in msb
	logic                 fix_hit;   // window matches a burst signature
	logic [bp_data_w-1:0] fix_d;     // data bits to flip in the oldest block
	bp_sig_t              fix_sig;   // signature of the burst being removed

	assign r_dat = r[bp_data_w-1:0];
	assign r_par = r[bp_data_w];

	// recompute the parity from what was received, any mismatch is a syndrome
	assign syn_now = r_par ^ bp_parity(r_dat, dly);
	assign sig_win = {syn_q, syn_now};

	// look the window up in the signature table
	// only odd weight bursts are usable, an even one leaves its own syndrome
	// clear and cannot be told apart from a burst one write younger
	always_comb
	begin
		fix_hit = 1'b0;
		fix_d   = '0;
		fix_sig = '0;
		for (int p = 1; p <= bp_pat_n; p++)
		begin
			if (^(bp_sym_w'(p)) && (sig_win == bp_sig_table[p]))
			begin
				fix_hit = 1'b1;
				fix_d   = bp_data_w'(p);      // low bits of the pattern are the data error
				fix_sig = bp_sig_table[p];
			end
		end
	end

	// oldest received block with the burst taken out
	assign d = dly[bp_depth-2] ^ fix_d;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			dly   <= '0;
			syn_q <= '0;
		end
		else if (ce)
		begin
			dly <= {dly[bp_depth-3:0], r_dat};
			// the oldest syndrome leaves, the burst's trace goes with the correction
			syn_q <= sig_win[bp_depth-2:0] ^ fix_sig[bp_depth-2:0];
		end
	end

	// a correction on a write needs a syndrome in the oldest slot
	a_fix_oldest: assert property (@(posedge clk) disable iff (!rst_n)
		(ce && fix_hit) |-> sig_win[bp_depth-1])
		else $error("bp437_dec: correction without oldest syndrome");

endmodule

// ==== bp437/bp437_enc.sv ====
`timescale 1ns/1ps

// one lane of the encoder
// data passes straight through, parity is appended in the msb
module bp437_enc
	import bp_code_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ce,     // advance one block
	input  logic [bp_data_w-1:0] u,      // data block of this lane
	output logic [bp_sym_w-1:0]  v       // code symbol {parity, data}
);

	bp_hist_t hist;     // six previous data blocks, [0] newest
	logic     par;      // parity of the current block

	// block history, shifts on every write to the code register
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			hist <= '0;
		end
		else if (ce)
		begin
			hist <= {hist[bp_depth-3:0], u};   // oldest block drops out
		end
	end

	// parity sees the block being written plus the stored ones
	assign par = bp_parity(u, hist);
	assign v   = {par, u};   // systematic, data in low bits

	// strobe must be clean, an x here corrupts the whole history
	a_ce_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(ce))
		else $error("bp437_enc: ce unknown");

endmodule

// ==== common/bp_code_pkg.sv ====
package bp_code_pkg;

	// lane geometry of the rate 3/4 code
	localparam int bp_data_w = 3;                      // data bits per lane block
	localparam int bp_sym_w  = 4;                      // code symbol per lane, parity on top
	localparam int bp_lanes  = 4;                      // interleave depth
	localparam int bp_depth  = 7;                      // current block plus six past blocks
	localparam int bp_pat_n  = (1 << bp_sym_w) - 1;    // nonzero error patterns in one symbol

	// parity taps, bit 3k+j is data bit j of the block k writes ago
	// k=0 covers all three bits, k=1..3 form a basis so each signature is unique
	localparam logic [bp_depth*bp_data_w-1:0] bp_taps = 21'b101_110_011_100_010_001_111;

	typedef logic [bp_depth-1:0] bp_sig_t;                        // syndrome window, oldest in msb
	typedef logic [bp_depth-2:0][bp_data_w-1:0] bp_hist_t;        // [0] is one write ago
	typedef bp_sig_t [bp_pat_n:1] bp_sig_tab_t;                   // indexed by error pattern

	// parity over current block and the six stored blocks
	function automatic logic bp_parity(input logic [bp_data_w-1:0] cur, input bp_hist_t hist);
		return ^({hist, cur} & bp_taps);   // concatenation lines up with tap bit 3k+j
	endfunction

	// syndrome history left behind by each error pattern once it reaches the oldest slot
	function automatic bp_sig_tab_t bp_sig_build();
		bp_sig_tab_t tab;
		logic [bp_sym_w-1:0] pat;
		logic [bp_data_w-1:0] ed;
		tab = '0;
		for (int p = 1; p <= bp_pat_n; p++)
		begin
			pat = bp_sym_w'(p);
			ed  = pat[bp_data_w-1:0];          // data part of the burst
			for (int k = 0; k < bp_depth; k++)
			begin
				// syndrome k writes after the burst
				tab[p][bp_depth-1-k] = ^(ed & bp_taps[bp_data_w*k +: bp_data_w]);
			end
			// a parity bit error shows only in the burst's own syndrome
			tab[p][bp_depth-1] = tab[p][bp_depth-1] ^ pat[bp_data_w];
		end
		return tab;
	endfunction

	localparam bp_sig_tab_t bp_sig_table = bp_sig_build();

endpackage

// ==== common/bp_host_pkg.sv ====
package bp_host_pkg;

	localparam int bp_word_w = 16;    // host data bus
	localparam int bp_addr_w = 1;     // only address bit 0 is decoded

	// register select on ioaddr
	// code: write data to encode, read code symbols
	// data: write received word, read decoded data
	typedef enum logic [bp_addr_w-1:0]
	{
		bp_reg_code = 1'b0,
		bp_reg_data = 1'b1
	} bp_reg_e;

endpackage

// ==== verif/bp437_model.svh ====
`ifndef bp437_model_svh
`define bp437_model_svh

// reference model of the lane code, built from the tap table and nothing else
// included in the testbench module body, after the package imports

logic [bp_data_w-1:0]          hist_ref [bp_lanes][bp_depth-1];   // per lane, [0] one write ago
logic [bp_lanes*bp_data_w-1:0] sent_dly [bp_depth-1];             // words sent, [0] newest
logic [15:0]                   lfsr_state = 16'd39880;            // fixed seed

// all zero code memory, as after reset
function automatic void clear_history();
	for (int i = 0; i < bp_lanes; i++)
	begin
		for (int k = 0; k < bp_depth - 1; k++)
			hist_ref[i][k] = '0;
	end
	for (int k = 0; k < bp_depth - 1; k++)
		sent_dly[k] = '0;
endfunction

// parity of one lane, tap bit 3k+j picks data bit j of the block k writes ago
function automatic logic lane_parity(input int lane, input logic [bp_data_w-1:0] cur);
	logic                 p;
	logic [bp_data_w-1:0] blk;
	p = 1'b0;
	for (int k = 0; k < bp_depth; k++)
	begin
		if (k == 0)
			blk = cur;                      // block being written
		else
			blk = hist_ref[lane][k-1];
		for (int j = 0; j < bp_data_w; j++)
			p = p ^ (bp_taps[bp_data_w*k + j] & blk[j]);
	end
	return p;
endfunction

// four symbols {parity, data} for one data word, then the lane histories advance
function automatic logic [bp_lanes*bp_sym_w-1:0] encode_word(
	input logic [bp_lanes*bp_data_w-1:0] data);
	logic [bp_lanes*bp_sym_w-1:0] code;
	logic [bp_data_w-1:0]         u;
	code = '0;
	for (int i = 0; i < bp_lanes; i++)
	begin
		u = data[bp_data_w*i +: bp_data_w];
		code[bp_sym_w*i +: bp_sym_w] = {lane_parity(i, u), u};
		for (int k = bp_depth - 2; k > 0; k--)
			hist_ref[i][k] = hist_ref[i][k-1];
		hist_ref[i][0] = u;
	end
	return code;
endfunction

// decoded data seen on this write is the word sent six writes back
function automatic logic [bp_lanes*bp_data_w-1:0] delay_word(
	input logic [bp_lanes*bp_data_w-1:0] data);
	logic [bp_lanes*bp_data_w-1:0] old;
	old = sent_dly[bp_depth-2];
	for (int k = bp_depth - 2; k > 0; k--)
		sent_dly[k] = sent_dly[k-1];
	sent_dly[0] = data;
	return old;
endfunction

// 16-bit fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic next_lfsr_bit();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

// n random bits in the low end, one lfsr step per bit
function automatic logic [15:0] random_bits(input int n);
	logic [15:0] v;
	v = '0;
	for (int b = 0; b < n; b++)
		v = {v[14:0], next_lfsr_bit()};
	return v;
endfunction

`endif

// ==== verif/bp437p16_tb.sv ====
`timescale 1ns/1ps

// testbench for the four lane codec
// the stimulus table is filled from the reference model first, then played on the DUT
module bp437p16_tb
	import bp_code_pkg::*, bp_host_pkg::*;
();

	localparam real clk_period   = 4.0;       // ns
	localparam real drive_delay  = 1.0;       // inputs move this long after the edge
	localparam real run_limit_ns = 20000.0;   // whole run
	localparam int  code_w       = bp_lanes * bp_sym_w;
	localparam int  data_w       = bp_lanes * bp_data_w;

	typedef enum logic [1:0]
	{
		op_reset,     // rst_n low for two edges
		op_encode,    // write code register, read symbols back
		op_receive,   // write data register with the mask applied, read decoded data
		op_read       // read the register named by data bit 0
	} op_e;

	typedef struct packed
	{
		op_e                  op;
		logic [bp_word_w-1:0] data;
		logic [bp_word_w-1:0] mask;     // burst on the received word
		logic [bp_word_w-1:0] result;   // expected dout
	} row_t;

	logic                 clk;
	logic                 rst_n;
	logic                 iocs;
	logic [bp_addr_w-1:0] ioaddr;
	logic [bp_word_w-1:0] din;
	logic [bp_word_w-1:0] dout;
	logic                 iord;
	logic                 iowr;

	row_t rows [$];          // stimulus and expected values

	`include "bp437_model.svh"

	bp437p16 u_dut
	(
		.clk    (clk),
		.rst_n  (rst_n),
		.iocs   (iocs),
		.ioaddr (ioaddr),
		.din    (din),
		.dout   (dout),
		.iord   (iord),
		.iowr   (iowr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// hard stop in case the clock or a loop stalls
	initial
	begin
		#(run_limit_ns);
		abort_run("simulation did not finish within its time limit");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at the first failure");
	endtask

	// n rising edges, then the drive delay
	// each edge must come within a period, else the clock is broken
	task automatic wait_edges(input int n);
		real deadline;
		int  seen;
		bit  late;
		deadline = $realtime + (n + 1) * clk_period;
		seen     = 0;
		late     = 1'b0;
		while (seen < n && !late)
		begin
			@(posedge clk);
			seen++;
			late = ($realtime > deadline);
		end
		if (late)
			abort_run($sformatf("clock edge %0d of %0d arrived too late", seen, n));
		else
			#(drive_delay);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		iocs  = 1'b0;
		iowr  = 1'b0;
		iord  = 1'b0;
		wait_edges(2);   // two edges with rst_n low
		rst_n = 1'b1;
	endtask

	task automatic write_reg(input bp_reg_e sel, input logic [bp_word_w-1:0] value);
		iocs   = 1'b1;
		iowr   = 1'b1;
		ioaddr = sel;
		din    = value;
		wait_edges(1);   // write edge, lanes shift here
		iocs   = 1'b0;
		iowr   = 1'b0;
		din    = '0;
	endtask

	task automatic read_reg(input bp_reg_e sel, output logic [bp_word_w-1:0] value);
		iocs   = 1'b1;
		iord   = 1'b1;
		ioaddr = sel;
		wait_edges(1);   // dout loads on this edge
		iocs   = 1'b0;
		iord   = 1'b0;
		value  = dout;   // sampled a ns after the edge
	endtask

	task automatic check_read(input int idx, input bp_reg_e sel,
		input logic [bp_word_w-1:0] result);
		logic [bp_word_w-1:0] got;
		read_reg(sel, got);
		assert (got === result)
		else
			abort_run($sformatf("Error at %0d ns: row %0d, %s read %h, expected %h",
				$time, idx, sel.name(), got, result));
	endtask

	function automatic void push_row(input op_e op, input logic [bp_word_w-1:0] data,
		input logic [bp_word_w-1:0] mask, input logic [bp_word_w-1:0] result);
		row_t row;
		row.op     = op;
		row.data   = data;
		row.mask   = mask;
		row.result = result;
		rows.push_back(row);
	endfunction

	// one word through encoder and decoder, the received copy may carry a burst
	function automatic void round_trip(input logic [data_w-1:0] data,
		input logic [bp_word_w-1:0] mask);
		logic [code_w-1:0] code;
		logic [data_w-1:0] old;
		code = encode_word(data);
		old  = delay_word(data);
		push_row(op_encode, bp_word_w'(data), '0, code);
		push_row(op_receive, code, mask, bp_word_w'(old));   // burst must not show
	endfunction

	function automatic logic [data_w-1:0] data_word();
		logic [bp_word_w-1:0] v;
		v = random_bits(data_w);
		return v[data_w-1:0];
	endfunction

	// one burst, any set of lanes hit
	// a hit nibble has odd weight, so the burst's own parity check fails
	function automatic logic [bp_word_w-1:0] burst_mask();
		logic [bp_word_w-1:0] m;
		logic [bp_word_w-1:0] pick;
		logic [bp_data_w-1:0] ed;
		m = '0;
		for (int i = 0; i < bp_lanes; i++)
		begin
			pick = random_bits(bp_sym_w);   // data error bits plus lane enable on top
			ed   = pick[bp_data_w-1:0];
			if (pick[bp_data_w])
				m[bp_sym_w*i +: bp_sym_w] = {~^ed, ed};
		end
		if (m == '0)
			m[bp_sym_w-1] = 1'b1;           // lone parity bit error in lane 0
		return m;
	endfunction

	// a burst and the clean words the decoder needs after it
	function automatic void burst_run(input int clean);
		logic [data_w-1:0]    d;
		logic [bp_word_w-1:0] m;
		d = data_word();
		m = burst_mask();
		round_trip(d, m);
		for (int c = 0; c < clean; c++)
			round_trip(data_word(), '0);
	endfunction

	function automatic void build_table();
		clear_history();
		push_row(op_reset, '0, '0, '0);
		push_row(op_read, bp_word_w'(bp_reg_code), '0, '0);   // zero out of reset
		push_row(op_read, bp_word_w'(bp_reg_data), '0, '0);
		for (int n = 0; n < 24; n++)
			round_trip(data_word(), '0);   // clean stream
		for (int b = 0; b < 4; b++)
			burst_run(bp_depth - 1 + b % 2);
		// seven zero data words flush both code memories
		for (int n = 0; n < bp_depth; n++)
			round_trip('0, '0);
		clear_history();
		push_row(op_read, bp_word_w'(bp_reg_code), '0, '0);
		push_row(op_read, bp_word_w'(bp_reg_data), '0, '0);
		for (int n = 0; n < 10; n++)
			round_trip(data_word(), '0);
		// reset in the middle of a stream
		push_row(op_reset, '0, '0, '0);
		clear_history();
		push_row(op_read, bp_word_w'(bp_reg_code), '0, '0);
		push_row(op_read, bp_word_w'(bp_reg_data), '0, '0);
		for (int n = 0; n < 8; n++)
			round_trip(data_word(), '0);
		burst_run(bp_depth - 1);
	endfunction

	initial
	begin
		rst_n  = 1'b0;
		iocs   = 1'b0;
		ioaddr = bp_reg_code;
		din    = '0;
		iord   = 1'b0;
		iowr   = 1'b0;
		build_table();
		foreach (rows[i])
		begin
			case (rows[i].op)
				op_reset:
					apply_reset();
				op_encode:
				begin
					write_reg(bp_reg_code, rows[i].data);
					check_read(i, bp_reg_code, rows[i].result);
				end
				op_receive:
				begin
					write_reg(bp_reg_data, rows[i].data ^ rows[i].mask);
					check_read(i, bp_reg_data, rows[i].result);
				end
				op_read:
					check_read(i, bp_reg_e'(rows[i].data[0]), rows[i].result);
			endcase
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== verilog/bp437p16.sv ====
`timescale 1ns/1ps

// host side of the codec, four interleaved lanes
// a 16-bit burst hits each lane in one symbol only
module bp437p16
	import bp_code_pkg::*, bp_host_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 iocs,     // chip select
	input  logic [bp_addr_w-1:0] ioaddr,   // register select
	input  logic [bp_word_w-1:0] din,      // write data
	output logic [bp_word_w-1:0] dout,     // read data, held between reads
	input  logic                 iord,     // read strobe
	input  logic                 iowr      // write strobe
);

	localparam int code_w = bp_lanes * bp_sym_w;    // four symbols
	localparam int data_w = bp_lanes * bp_data_w;   // four data blocks

	bp_reg_e           reg_sel;
	logic              enc_we;     // word to encode
	logic              dec_we;     // received word
	logic [code_w-1:0] enc_sym;    // encoder lanes, combinational
	logic [data_w-1:0] dec_dat;    // decoder lanes, combinational
	logic [code_w-1:0] code_q;     // code register
	logic [data_w-1:0] data_q;     // decoded register

	assign reg_sel = bp_reg_e'(ioaddr);

	// write strobes
	assign enc_we = iocs & iowr & (reg_sel == bp_reg_code);
	assign dec_we = iocs & iowr & (reg_sel == bp_reg_data);

	// lane i takes data bits 3i+2..3i and symbol bits 4i+3..4i
	for (genvar i = 0; i < bp_lanes; i++)
	begin : g_lane
		bp437_enc u_enc
		(
			.clk   (clk),
			.rst_n (rst_n),
			.ce    (enc_we),
			.u     (din[bp_data_w*i +: bp_data_w]),
			.v     (enc_sym[bp_sym_w*i +: bp_sym_w])
		);

		bp437_dec u_dec
		(
			.clk   (clk),
			.rst_n (rst_n),
			.ce    (dec_we),
			.r     (din[bp_sym_w*i +: bp_sym_w]),
			.d     (dec_dat[bp_data_w*i +: bp_data_w])
		);
	end

	// result registers and registered read mux
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			code_q <= '0;
			data_q <= '0;
			dout   <= '0;
		end
		else
		begin
			if (enc_we)
				code_q <= enc_sym;     // symbols of this write
			if (dec_we)
				data_q <= dec_dat;     // data of six writes back
			if (iord)
			begin
				if (reg_sel == bp_reg_data)
					dout <= bp_word_w'(data_q);   // upper nibble reads zero
				else
					dout <= bp_word_w'(code_q);
			end
		end
	end

	// host never reads and writes in the same access
	a_no_rdwr: assert property (@(posedge clk) disable iff (!rst_n) iocs |-> !(iowr && iord))
		else $error("bp437p16: iord and iowr together");

endmodule
